/* Makefile */
# Verilator build and run for the background pixel pipe

SIM      := verilator
TOP      := bg_pixel_pipe_tb
FILELIST := build.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
PASS_MSG := test passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+hw
hw/ppu_types_pkg.sv
hw/pixel_fifo.sv
hw/tile_fetcher.sv
hw/pixel_shifter.sv
hw/bg_pixel_pipe.sv
dv/bg_pixel_pipe_tb.sv

/* dv/bg_pixel_pipe_tb.sv */
`timescale 1ns/100ps
`include "ppu_consts.svh"

module bg_pixel_pipe_tb;
  import ppu_types_pkg::*;

  localparam int NUM_LINES    = 40;
  localparam int LINE_TIMEOUT = 2000;

  logic        clk;
  logic        reset;
  logic        line_start;
  logic [7:0]  ly;
  logic [7:0]  scx;
  logic [7:0]  scy;
  logic        map_sel;
  logic        tiledata_sel;
  logic [7:0]  bgp;
  logic        vram_rd;
  logic [12:0] vram_addr;
  logic [7:0]  vram_data = 8'h00;
  logic        pixel_valid;
  logic [7:0]  pixel_x;
  gb_shade_t   pixel_shade;
  logic        line_done;

  // Video RAM contents, 8 KiB
  logic [7:0]  vram [8192];
  integer      seed;
  // Model output for the current line
  gb_shade_t   expected [`PPU_SCREEN_WIDTH];

  bg_pixel_pipe i_bg_pixel_pipe (
    .clk          (clk),
    .reset        (reset),
    .line_start   (line_start),
    .ly           (ly),
    .scx          (scx),
    .scy          (scy),
    .map_sel      (map_sel),
    .tiledata_sel (tiledata_sel),
    .bgp          (bgp),
    .vram_rd      (vram_rd),
    .vram_addr    (vram_addr),
    .vram_data    (vram_data),
    .pixel_valid  (pixel_valid),
    .pixel_x      (pixel_x),
    .pixel_shade  (pixel_shade),
    .line_done    (line_done)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // ==============================
  // Video RAM model
  // ==============================

  // Byte valid for the whole cycle after the read
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      vram_data <= 8'h00;
    end else if (vram_rd) begin
      vram_data <= vram[vram_addr];
    end
  end

  // ==============================
  // Checking helpers
  // ==============================
  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected_val);
    if (actual !== expected_val) begin
      $display("CHECK FAILED at %0t ns: %s got %0d, expected %0d",
               $time, name, actual, expected_val);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("test failed");
    $fatal(1, "stopped on error");
  endtask

  // ==============================
  // Reference model
  // ==============================

  // Fills expected[] from the current line inputs and vram[]
  function automatic void compute_expected_line();
    int          row;
    int          src;
    int          col;
    int          tile;
    int          color;
    logic [12:0] map_addr;
    logic [12:0] data_addr;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [2:0]  bit_pos;
    logic [7:0]  shade_bits;
    row = (int'(ly) + int'(scy)) % 256;
    for (int x = 0; x < `PPU_SCREEN_WIDTH; x++) begin
      // Screen pixel plus the fine scroll offset
      src      = x + int'(scx) % 8;
      col      = (int'(scx) / 8 + src / 8) % 32;
      map_addr = 13'((map_sel ? 32'h1C00 : 32'h1800) + (row / 8) * 32 + col);
      tile     = int'(vram[map_addr]);
      // 8800 mode, tile number is two's complement
      if (!tiledata_sel && tile > 127) begin
        tile = tile - 256;
      end
      data_addr = 13'((tiledata_sel ? 0 : 32'h1000) + tile * 16 + (row % 8) * 2);
      lo        = vram[data_addr];
      hi        = vram[data_addr + 13'd1];
      // MSB is the leftmost pixel
      bit_pos    = 3'(7 - src % 8);
      color      = 2 * int'(hi[bit_pos]) + int'(lo[bit_pos]);
      shade_bits = bgp >> (2 * color);
      expected[8'(x)] = shade_bits[1:0];
    end
  endfunction

  // ==============================
  // One scanline
  // ==============================

  // abort_after > 0 restarts the path after that many pixels
  task automatic run_line(input int line_idx, input int abort_after);
    int          count;
    int          cycles;
    bit          done;
    bit          prev_valid;
    logic [12:0] first_map;
    @(posedge clk);
    #10;
    ly           = 8'($random(seed));
    // Low scx bits step through every fine scroll value
    scx          = {5'($random(seed)), 3'(line_idx % 8)};
    scy          = 8'($random(seed));
    map_sel      = line_idx[3];
    tiledata_sel = line_idx[4];
    bgp          = 8'($random(seed));
    line_start   = 1'b1;
    compute_expected_line();
    // Map entry of the first tile on the line
    first_map = 13'((map_sel ? 32'h1C00 : 32'h1800)
                    + ((int'(ly) + int'(scy)) % 256 / 8) * 32 + int'(scx) / 8);
    @(posedge clk);
    #10;
    line_start = 1'b0;
    count      = 0;
    cycles     = 0;
    done       = 1'b0;
    prev_valid = 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > LINE_TIMEOUT) begin
        abort_run("line_done did not arrive before the line timeout");
      end else begin
        if (cycles == 1) begin
          // Fetch opens with the map read
          compare_value("vram_rd", 32'(vram_rd), 32'd1);
          compare_value("vram_addr", 32'(vram_addr), 32'(first_map));
        end
        if (line_done) begin
          compare_value("line_done pixel count", 32'(count), 32'(`PPU_SCREEN_WIDTH));
          compare_value("pixel_valid before line_done", 32'(prev_valid), 32'd1);
          done = 1'b1;
        end
        if (pixel_valid) begin
          if (count >= `PPU_SCREEN_WIDTH) begin
            abort_run("more than 160 pixels were emitted in one line");
          end else begin
            compare_value("pixel_x", 32'(pixel_x), 32'(count));
            compare_value("pixel_shade", 32'(pixel_shade), 32'(expected[8'(count)]));
            count++;
          end
        end
        prev_valid = pixel_valid;
        if (abort_after > 0 && count == abort_after) begin
          done = 1'b1;
        end
      end
    end
    // Line end must leave the outputs quiet
    if (abort_after == 0) begin
      repeat (3) begin
        @(negedge clk);
        compare_value("pixel_valid after line_done", 32'(pixel_valid), 32'd0);
        compare_value("line_done", 32'(line_done), 32'd0);
        // Fetcher idle once the line is over
        compare_value("vram_rd after line_done", 32'(vram_rd), 32'd0);
      end
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    seed         = 32'h95e46d4f;
    clk          = 1'b0;
    reset        = 1'b1;
    line_start   = 1'b0;
    ly           = 8'h00;
    scx          = 8'h00;
    scy          = 8'h00;
    map_sel      = 1'b0;
    tiledata_sel = 1'b0;
    bgp          = 8'h00;
    for (int a = 0; a < 8192; a++) begin
      vram[13'(a)] = 8'($random(seed));
    end
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;
    for (int n = 0; n < NUM_LINES; n++) begin
      // Every fifth line is cut short by a new line_start
      if (n % 5 == 4) begin
        run_line(n, 1 + int'($random(seed) & 32'h7f));
      end else begin
        run_line(n, 0);
      end
    end
    $display("test passed");
    $finish;
  end

endmodule

/* hw/bg_pixel_pipe.sv */
`timescale 1ns/100ps

module bg_pixel_pipe (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     line_start,
  input  logic [7:0]               ly,
  input  logic [7:0]               scx,
  input  logic [7:0]               scy,
  input  logic                     map_sel,
  input  logic                     tiledata_sel,
  input  logic [7:0]               bgp,
  output logic                     vram_rd,
  output logic [12:0]              vram_addr,
  input  logic [7:0]               vram_data,
  output logic                     pixel_valid,
  output logic [7:0]               pixel_x,
  output ppu_types_pkg::gb_shade_t pixel_shade,
  output logic                     line_done
);
  import ppu_types_pkg::*;

  // ==============================
  // Internal links
  // ==============================

  // Fetcher to FIFO
  logic       fifo_write;
  pixel_row_t fifo_row;
  // FIFO to shifter
  logic       fifo_empty;
  gb_color_t  fifo_pixel;
  logic       fifo_pop;

  // Tile fetch from video RAM
  tile_fetcher i_tile_fetcher (
    .clk          (clk),
    .reset        (reset),
    .line_start   (line_start),
    .ly           (ly),
    .scx          (scx),
    .scy          (scy),
    .map_sel      (map_sel),
    .tiledata_sel (tiledata_sel),
    .line_done    (line_done),
    .vram_rd      (vram_rd),
    .vram_addr    (vram_addr),
    .vram_data    (vram_data),
    .fifo_empty   (fifo_empty),
    .fifo_write   (fifo_write),
    .fifo_row     (fifo_row)
  );

  // One tile row buffer, flushed on every line start
  pixel_fifo i_pixel_fifo (
    .clk        (clk),
    .reset      (reset),
    .flush      (line_start),
    .write_en   (fifo_write),
    .write_data (fifo_row),
    .read_en    (fifo_pop),
    .read_data  (fifo_pixel),
    .empty      (fifo_empty)
  );

  // Fine scroll, palette and x count
  pixel_shifter i_pixel_shifter (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .scx         (scx),
    .bgp         (bgp),
    .fifo_empty  (fifo_empty),
    .fifo_pixel  (fifo_pixel),
    .fifo_pop    (fifo_pop),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_shade (pixel_shade),
    .line_done   (line_done)
  );

endmodule

/* hw/pixel_fifo.sv */
`timescale 1ns/100ps
`include "ppu_consts.svh"

module pixel_fifo (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      write_en,
  input  ppu_types_pkg::pixel_row_t write_data,
  input  logic                      read_en,
  output ppu_types_pkg::gb_color_t  read_data,
  output logic                      empty
);
  import ppu_types_pkg::*;

  // Storage for one tile row
  gb_color_t buffer [`PPU_FIFO_DEPTH];

  logic [2:0] read_ptr;
  logic [3:0] count;
  logic       do_pop;

  // Pop only counts while something is held
  assign do_pop = read_en && !empty;

  // ==============================
  // Bulk load
  // ==============================

  // All eight entries in one edge
  always_ff @(posedge clk) begin
    if (write_en) begin
      for (int i = 0; i < `PPU_FIFO_DEPTH; i++) begin
        buffer[i] <= write_data[i];
      end
    end
  end

  // ==============================
  // Pointer and fill count
  // ==============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      read_ptr <= 3'd0;
      count    <= 4'd0;
    end else if (flush) begin
      // Line restart drops whatever is left
      read_ptr <= 3'd0;
      count    <= 4'd0;
    end else if (write_en) begin
      count <= 4'(`PPU_FIFO_DEPTH);
    end else if (do_pop) begin
      // Pointer wraps back to 0 after the eighth pop
      read_ptr <= read_ptr + 3'd1;
      count    <= count - 4'd1;
    end
  end

  // Head entry, no read latency
  assign read_data = buffer[read_ptr];
  assign empty     = (count == 4'd0);

  // ==============================
  // Protocol checks
  // ==============================

  // Fetcher must wait for a drained buffer
  a_write_when_empty: assert property (@(posedge clk) disable iff (reset)
    write_en |-> empty);

  // Row must land aligned with the read side
  a_write_ptr_zero: assert property (@(posedge clk) disable iff (reset)
    write_en |-> (read_ptr == 3'd0));

  // Shifter never pops a dry buffer
  a_pop_when_full: assert property (@(posedge clk) disable iff (reset)
    read_en |-> !empty);

endmodule

/* hw/pixel_shifter.sv */
`timescale 1ns/100ps
`include "ppu_consts.svh"

module pixel_shifter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     line_start,
  input  logic [7:0]               scx,
  input  logic [7:0]               bgp,
  input  logic                     fifo_empty,
  input  ppu_types_pkg::gb_color_t fifo_pixel,
  output logic                     fifo_pop,
  output logic                     pixel_valid,
  output logic [7:0]               pixel_x,
  output ppu_types_pkg::gb_shade_t pixel_shade,
  output logic                     line_done
);
  import ppu_types_pkg::*;

  // Line in progress, cleared after the last pixel
  logic       active;
  // Fine scroll pixels still to drop
  logic [2:0] discard;
  logic [7:0] palette;
  // Screen position of the next kept pixel
  logic [7:0] x_count;
  logic       last_pixel;
  logic       keep;

  // Two palette bits per colour index
  function automatic gb_shade_t apply_palette(input logic [7:0] pal,
                                              input gb_color_t  color);
    return gb_shade_t'(pal[{color, 1'b0} +: 2]);
  endfunction

  // ==============================
  // Pop control
  // ==============================
  assign fifo_pop   = active && !fifo_empty;
  assign keep       = fifo_pop && (discard == 3'd0);
  assign last_pixel = (x_count == 8'(`PPU_SCREEN_WIDTH - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active      <= 1'b0;
      discard     <= 3'd0;
      x_count     <= 8'd0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else if (line_start) begin
      // Restart, also mid line
      active      <= 1'b1;
      discard     <= scx[2:0];
      x_count     <= 8'd0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= keep;
      // One cycle behind the final pixel
      line_done   <= pixel_valid && (pixel_x == 8'(`PPU_SCREEN_WIDTH - 1));
      if (fifo_pop) begin
        if (discard != 3'd0) begin
          discard <= discard - 3'd1;
        end else begin
          x_count <= x_count + 8'd1;
          if (last_pixel) begin
            active <= 1'b0;
          end
        end
      end
    end
  end

  // ==============================
  // Pixel output
  // ==============================
  always_ff @(posedge clk) begin
    if (line_start) begin
      palette <= bgp;
    end
    if (keep) begin
      pixel_x     <= x_count;
      pixel_shade <= apply_palette(palette, fifo_pixel);
    end
  end

  // Never past the right edge
  a_x_in_range: assert property (@(posedge clk) disable iff (reset)
    pixel_valid |-> (pixel_x <= 8'(`PPU_SCREEN_WIDTH - 1)));

endmodule

/* hw/ppu_consts.svh */
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// ==============================
// Line geometry
// ==============================

// Pixels per tile row, also the FIFO depth
`define PPU_FIFO_DEPTH 8

// Visible pixels per scanline
`define PPU_SCREEN_WIDTH 160

// ==============================
// Video RAM layout, 13-bit offsets
// ==============================

// Background tile maps, 32x32 entries each
`define PPU_MAP0_BASE 13'h1800
`define PPU_MAP1_BASE 13'h1C00

// Tile data, unsigned 8000 mode and signed 8800 mode
`define PPU_TILE_BASE0 13'h0000
`define PPU_TILE_BASE1 13'h1000

`endif

/* hw/ppu_types_pkg.sv */
`include "ppu_consts.svh"

package ppu_types_pkg;

  // ==============================
  // Pixel data
  // ==============================

  // Colour index straight out of the bitplanes
  typedef logic [1:0] gb_color_t;

  // One decoded tile row, element 0 is leftmost
  typedef gb_color_t [`PPU_FIFO_DEPTH-1:0] pixel_row_t;

  // Palette output, 0 lightest, 3 darkest
  typedef logic [1:0] gb_shade_t;

  // ==============================
  // Fetcher states
  // ==============================
  typedef enum logic [2:0] {
    IDLE,
    GET_TILE,
    GET_LO,
    GET_HI,
    WAIT_HI,
    PUSH
  } fetch_state_t;

endpackage

/* hw/tile_fetcher.sv */
`timescale 1ns/100ps
`include "ppu_consts.svh"

module tile_fetcher (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      line_start,
  input  logic [7:0]                ly,
  input  logic [7:0]                scx,
  input  logic [7:0]                scy,
  input  logic                      map_sel,
  input  logic                      tiledata_sel,
  input  logic                      line_done,
  output logic                      vram_rd,
  output logic [12:0]               vram_addr,
  input  logic [7:0]                vram_data,
  input  logic                      fifo_empty,
  output logic                      fifo_write,
  output ppu_types_pkg::pixel_row_t fifo_row
);
  import ppu_types_pkg::*;

  fetch_state_t state;
  fetch_state_t state_next;

  // Line values captured at line_start
  logic [7:0]  line_row;
  logic        map_sel_q;
  logic        tiledata_sel_q;

  // Map column of the tile being fetched
  logic [4:0]  tile_col;

  // Bytes collected for the current tile
  logic [7:0]  tile_num;
  logic [7:0]  plane_lo;
  logic [7:0]  plane_hi;

  logic [12:0] map_addr;

  // Tile data address, signed tile number in 8800 mode
  function automatic logic [12:0] data_addr(input logic [7:0] tile,
                                            input logic       unsigned_mode,
                                            input logic [2:0] fine_row,
                                            input logic       plane);
    logic [12:0] tile_base;
    if (unsigned_mode) begin
      tile_base = `PPU_TILE_BASE0 + {1'b0, tile, 4'b0000};
    end else begin
      // Sign extension, wraps mod 8 KiB
      tile_base = `PPU_TILE_BASE1 + {tile[7], tile, 4'b0000};
    end
    return tile_base + {9'd0, fine_row, plane};
  endfunction

  // Map entry for (row / 8, column)
  assign map_addr = (map_sel_q ? `PPU_MAP1_BASE : `PPU_MAP0_BASE)
                  + {3'b000, line_row[7:3], tile_col};

  // ==============================
  // State machine
  // ==============================
  always_comb begin
    state_next = state;
    case (state)
      IDLE:     state_next = IDLE;
      GET_TILE: state_next = GET_LO;
      GET_LO:   state_next = GET_HI;
      GET_HI:   state_next = WAIT_HI;
      WAIT_HI:  state_next = PUSH;
      PUSH: begin
        // Hold here until the shifter drains the FIFO
        if (fifo_empty) begin
          state_next = GET_TILE;
        end
      end
      default:  state_next = IDLE;
    endcase
    if (line_done) begin
      state_next = IDLE;
    end
    // Restart wins over line end
    if (line_start) begin
      state_next = GET_TILE;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= IDLE;
      tile_col <= 5'd0;
    end else begin
      state <= state_next;
      if (line_start) begin
        // Coarse scroll picks the first column
        tile_col <= scx[7:3];
      end else if (fifo_write) begin
        // Natural wrap at 32
        tile_col <= tile_col + 5'd1;
      end
    end
  end

  // ==============================
  // Line latch and byte capture
  // ==============================
  always_ff @(posedge clk) begin
    if (line_start) begin
      line_row       <= ly + scy;
      map_sel_q      <= map_sel;
      tiledata_sel_q <= tiledata_sel;
    end
    // Each byte arrives one cycle after its read
    case (state)
      GET_LO:  tile_num <= vram_data;
      GET_HI:  plane_lo <= vram_data;
      WAIT_HI: plane_hi <= vram_data;
      default: ;
    endcase
  end

  // ==============================
  // Video RAM requests
  // ==============================
  always_comb begin
    vram_rd   = 1'b0;
    vram_addr = 13'd0;
    case (state)
      GET_TILE: begin
        vram_rd   = 1'b1;
        vram_addr = map_addr;
      end
      GET_LO: begin
        // Tile number is on the bus this cycle
        vram_rd   = 1'b1;
        vram_addr = data_addr(vram_data, tiledata_sel_q, line_row[2:0], 1'b0);
      end
      GET_HI: begin
        vram_rd   = 1'b1;
        vram_addr = data_addr(tile_num, tiledata_sel_q, line_row[2:0], 1'b1);
      end
      default: ;
    endcase
  end

  // ==============================
  // Row decode and push
  // ==============================

  // Bit 7 of each plane is the leftmost pixel
  always_comb begin
    for (int i = 0; i < `PPU_FIFO_DEPTH; i++) begin
      fifo_row[i] = {plane_hi[3'(7 - i)], plane_lo[3'(7 - i)]};
    end
  end

  assign fifo_write = (state == PUSH) && fifo_empty;

  // No fetch traffic while idle or waiting to push
  a_no_read_idle_push: assert property (@(posedge clk) disable iff (reset)
    (state inside {IDLE, PUSH}) |-> !vram_rd);

endmodule
